// File: list.f
verilog/ahbPkg.sv
verilog/matrixPkg.sv
verilog/addrHoldFsm.sv
verilog/addressStage.sv
verilog/dataPhaseSelect.sv
verilog/errorResponseTimer.sv
verilog/masterStage.sv
test/masterStage_asserts.sv
test/tb_masterStage.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and fails unless the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_masterStage -f list.f \
	&& ./obj_dir/Vtb_masterStage | tee /dev/stderr | grep -x "TB PASSED" > /dev/null \
	&& echo "Simulation run passed" \
	|| { echo "Simulation run failed"; exit 1; }

// File: test/masterStage_asserts.sv
// Protocol checks bound into masterStage; holdSel and defSel are taken from its internal nets
`timescale 1ns/1ns

module masterStage_asserts
(
	input  logic HCLK,
	input  logic aresetn,
	input  matrixPkg::slotMask_t saddrSel,
	input  ahbPkg::ahbCtrl_t gatedCtrl,
	input  logic holdSel,
	input  logic defSel,
	input  ahbPkg::hresp_e hresp
);

	import ahbPkg::*;

	// At most one slot sees the address phase
	saddrOneHot: assert property (@(posedge HCLK) disable iff (!aresetn) $onehot0(saddrSel))
		else $error("saddrSel selects more than one slot: %b", saddrSel);

	// The first held cycle must replay what was seen live at the capture edge
	heldCtrlStable: assert property (@(posedge HCLK) disable iff (!aresetn)
		holdSel |-> $stable(gatedCtrl))
		else $error("gatedCtrl changed while the address was held");

	defaultErr: assert property (@(posedge HCLK) disable iff (!aresetn)
		defSel |-> (hresp == ERROR))
		else $error("Default slave selected but hresp is not ERROR");

endmodule

bind masterStage masterStage_asserts asserts_i
(
	.HCLK(HCLK),
	.aresetn(aresetn),
	.saddrSel(saddrSel),
	.gatedCtrl(gatedCtrl),
	.holdSel(holdSel),
	.defSel(defSel),
	.hresp(hresp)
);

// File: test/tb_masterStage.sv
// Slot 5 disabled and two error wait states; slave models here keep hreadyout high outside waits
`timescale 1ns/1ns

module tb_masterStage;

	import ahbPkg::*;
	import matrixPkg::*;

	localparam int NumTests = 8;
	localparam int Timeout = 50;	// Cycles allowed per wait
	localparam int ErrWaits = 2;
	localparam slotMask_t SlotEn = 8'b1101_1111;	// Slot 5 off
	localparam int NoSlot = -1;	// IDLE transfer
	localparam int ErrSlot = -2;	// Default slave answers

	typedef struct
	{
		string name;
		addr_t addr;
		htrans_e htrans;
		int addrDelay;	// Cycles with addrReady low
		int dataWait;	// Cycles with hreadyout low
		int expSlot;
	} stimEntry_t;

	logic HCLK = 1'b0;
	logic aresetn;
	ahbCtrl_t mCtrl;
	slotRspArr_t sRsp;
	logic hreadyM;
	hresp_e hresp;
	data_t hrdata;
	ahbCtrl_t gatedCtrl;
	slotMask_t saddrSel;
	slotMask_t sdataSel;

	stimEntry_t stimTable [NumTests];
	data_t slotWord [NumSlots];
	logic [31:0] lfsr = 32'd48;
	int valueErrs = 0;
	int otherErrs = 0;
	logic timedOut = 1'b0;

	masterStage #(
		.SlotEnable(SlotEn),
		.ErrWaitStates(ErrWaits)
	) dut_i (
		.HCLK(HCLK),
		.aresetn(aresetn),
		.mCtrl(mCtrl),
		.hreadyM(hreadyM),
		.hresp(hresp),
		.hrdata(hrdata),
		.gatedCtrl(gatedCtrl),
		.saddrSel(saddrSel),
		.sdataSel(sdataSel),
		.sRsp(sRsp)
	);

	always #10 HCLK = ~HCLK;

	// Taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic ahbCtrl_t makeCtrl(input addr_t addr, input htrans_e htrans);
		ahbCtrl_t c;
		c.haddr = addr;
		c.htrans = htrans;
		c.hsize = 3'b010;	// Word
		c.hburst = 3'b000;
		c.hwrite = 1'b0;
		return c;
	endfunction

	function automatic stimEntry_t makeEntry(input string name, input addr_t addr,
		input htrans_e htrans, input int addrDelay, input int dataWait, input int expSlot);
		stimEntry_t e;
		e.name = name;
		e.addr = addr;
		e.htrans = htrans;
		e.addrDelay = addrDelay;
		e.dataWait = dataWait;
		e.expSlot = expSlot;
		return e;
	endfunction

	task automatic loadTable();
		stimTable[0] = makeEntry("slot0Ready", 32'h0000_0040, NONSEQ, 0, 0, 0);
		stimTable[1] = makeEntry("slot3Ready", 32'h3000_0100, NONSEQ, 0, 0, 3);
		stimTable[2] = makeEntry("slot7Hold3", 32'h7000_0008, NONSEQ, 3, 0, 7);
		stimTable[3] = makeEntry("slot5Off", 32'h5000_0010, NONSEQ, 0, 0, ErrSlot);
		stimTable[4] = makeEntry("reservedHi", 32'h9000_0000, NONSEQ, 0, 0, ErrSlot);
		stimTable[5] = makeEntry("idleSlot2", 32'h2000_0000, IDLE, 0, 0, NoSlot);
		stimTable[6] = makeEntry("slot1Wait3", 32'h1000_0020, NONSEQ, 0, 3, 1);
		stimTable[7] = makeEntry("slot6HoldWait", 32'h6000_0004, SEQ, 1, 2, 6);
	endtask

	task automatic reportValue(input string name, input string what, input logic [63:0] expVal,
		input logic [63:0] actVal);
		valueErrs++;
		$display("ERR %s %s: expected %0h, actual %0h", name, what, expVal, actVal);
	endtask

	task automatic reportOther(input string msg);
		otherErrs++;
		$display("%s", msg);
	endtask

	// Fresh read word for every slot with one LFSR step per bit
	task automatic fillSlotData();
		for (int s = 0; s < NumSlots; s++)
		begin
			for (int b = 0; b < 32; b++)
			begin
				slotWord[s][b] = lfsr[0];
				lfsr = galoisStep(lfsr);
			end
			sRsp[s].hrdata = slotWord[s];
		end
	endtask

	task automatic waitReady(input string name);
		int n;
		n = 0;
		while (!hreadyM && n < Timeout)
		begin
			@(negedge HCLK);
			#2;
			n++;
		end
		if (!hreadyM)
		begin
			reportOther($sformatf("Timeout: %s address phase never saw hreadyM high", name));
			timedOut = 1'b1;
		end
	endtask

	task automatic runEntry(input int idx);
		stimEntry_t e;
		string name;
		ahbCtrl_t xfer;
		ahbCtrl_t idleCtrl;
		slotIdx_t slot;
		slotMask_t expSel;
		data_t expData;
		hresp_e expResp;
		int expLow;
		int lowCycles;
		e = stimTable[idx];
		name = e.name;
		xfer = makeCtrl(e.addr, e.htrans);
		idleCtrl = makeCtrl(~e.addr, IDLE);
		slot = '0;
		expSel = '0;
		expData = '0;
		expResp = OKAY;
		expLow = e.dataWait;
		@(negedge HCLK);
		fillSlotData();
		for (int s = 0; s < NumSlots; s++)
		begin
			sRsp[s].hreadyout = 1'b1;
			sRsp[s].addrReady = 1'b1;
		end
		if (e.expSlot >= 0)
		begin
			slot = slotIdx_t'(e.expSlot);
			expSel = slotMask_t'(1) << slot;
			expData = slotWord[slot];
			sRsp[slot].addrReady = (e.addrDelay == 0);
		end
		else if (e.expSlot == ErrSlot)
		begin
			expResp = ERROR;
			expLow = ErrWaits;
		end
		mCtrl = xfer;
		#2;
		if (saddrSel !== expSel)
			reportValue(name, "saddrSel", 64'(expSel), 64'(saddrSel));
		if (gatedCtrl !== xfer)
			reportValue(name, "gatedCtrl", 64'(xfer), 64'(gatedCtrl));
		// The master moves on while the slot still refuses the address
		for (int k = 1; k <= e.addrDelay; k++)
		begin
			@(negedge HCLK);
			mCtrl = idleCtrl;
			if (k == e.addrDelay)
				sRsp[slot].addrReady = 1'b1;
			#2;
			if (gatedCtrl !== xfer)
				reportValue(name, "held gatedCtrl", 64'(xfer), 64'(gatedCtrl));
		end
		waitReady(name);
		if (timedOut)
			return;
		@(negedge HCLK);	// Data phase begins
		mCtrl = idleCtrl;
		if (e.dataWait > 0)
			sRsp[slot].hreadyout = 1'b0;
		#2;
		if (gatedCtrl !== idleCtrl)
			reportValue(name, "live gatedCtrl", 64'(idleCtrl), 64'(gatedCtrl));
		if (sdataSel !== expSel)
			reportValue(name, "sdataSel", 64'(expSel), 64'(sdataSel));
		lowCycles = 0;
		while (!hreadyM && lowCycles < Timeout)
		begin
			if (sdataSel !== expSel)
				reportValue(name, "sdataSel in wait", 64'(expSel), 64'(sdataSel));
			if (hresp !== expResp)
				reportValue(name, "hresp in wait", 64'(expResp), 64'(hresp));
			@(negedge HCLK);
			lowCycles++;
			if (e.dataWait > 0 && lowCycles == e.dataWait)
				sRsp[slot].hreadyout = 1'b1;
			#2;
		end
		if (!hreadyM)
		begin
			reportOther($sformatf("Timeout: %s data phase never completed", name));
			timedOut = 1'b1;
			return;
		end
		if (lowCycles != expLow)
			reportValue(name, "wait cycles", 64'(expLow), 64'(lowCycles));
		if (hresp !== expResp)
			reportValue(name, "hresp", 64'(expResp), 64'(hresp));
		if (hrdata !== expData)
			reportValue(name, "hrdata", 64'(expData), 64'(hrdata));
	endtask

	initial
	begin
		aresetn = 1'b0;
		mCtrl = makeCtrl('0, IDLE);
		sRsp = '0;
		for (int s = 0; s < NumSlots; s++)
		begin
			sRsp[s].hreadyout = 1'b1;
			sRsp[s].addrReady = 1'b1;
		end
		loadTable();
		repeat (16) @(negedge HCLK);
		aresetn = 1'b1;
		#2;
		if (hreadyM !== 1'b1)
			reportValue("afterReset", "hreadyM", 64'd1, 64'(hreadyM));
		if (hresp !== OKAY)
			reportValue("afterReset", "hresp", 64'(OKAY), 64'(hresp));
		if (sdataSel !== '0)
			reportValue("afterReset", "sdataSel", 64'd0, 64'(sdataSel));
		for (int i = 0; i < NumTests; i++)
		begin
			if (!timedOut)
				runEntry(i);
		end
		$display("Errors: %0d value, %0d other", valueErrs, otherErrs);
		if (valueErrs == 0 && otherErrs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: verilog/addrHoldFsm.sv
// Address hold control; assumes addrPending is decoded from the gated (live or held) transfer
`timescale 1ns/1ns

module addrHoldFsm
(
	input  logic HCLK,
	input  logic aresetn,
	input  logic addrPending,
	input  logic hreadyM,
	output logic capture,
	output logic holdSel
);

	typedef enum logic
	{
		LIVE = 1'b0,
		HELD = 1'b1
	} holdState_e;

	holdState_e state;
	holdState_e nextState;
	logic nextHoldSel;

	always_comb
	begin
		capture = 1'b0;
		nextHoldSel = 1'b0;
		nextState = state;
		case (state)
			LIVE:
			begin
				// Master finished its address phase but the slot refused it
				if (addrPending && hreadyM)
				begin
					capture = 1'b1;
					nextHoldSel = 1'b1;
					nextState = HELD;
				end
			end
			HELD:
			begin
				if (addrPending)
					nextHoldSel = 1'b1;	// Keep replaying
				else
					nextState = LIVE;	// Slot took it this cycle
			end
			default: nextState = LIVE;
		endcase
	end

	always_ff @(posedge HCLK or negedge aresetn)
	begin
		if (!aresetn)
		begin
			state <= LIVE;
			holdSel <= 1'b0;
		end
		else
		begin
			state <= nextState;
			holdSel <= nextHoldSel;
		end
	end

endmodule

// File: verilog/addressStage.sv
// Address capture and decode; haddr[30:28] picks the slot, haddr[31] is reserved, no remap
`timescale 1ns/1ns

module addressStage
#(
	parameter matrixPkg::slotMask_t SlotEnable = '1
)
(
	input  logic HCLK,
	input  logic aresetn,
	input  ahbPkg::ahbCtrl_t mCtrl,
	input  logic capture,
	input  logic holdSel,
	input  matrixPkg::slotRspArr_t sRsp,
	output ahbPkg::ahbCtrl_t gatedCtrl,
	output matrixPkg::slotMask_t saddrSel,
	output logic reservedSel,
	output logic addrPending
);

	import ahbPkg::*;
	import matrixPkg::*;

	ahbCtrl_t heldCtrl;
	slotIdx_t slot;
	slotMask_t slotDec;
	slotMask_t addrReadyVec;
	logic isTransfer;
	logic inReserved;

	// Refused address and control replayed while holdSel is high
	always_ff @(posedge HCLK or negedge aresetn)
	begin
		if (!aresetn)
			heldCtrl <= '0;
		else if (capture)
			heldCtrl <= mCtrl;
	end

	assign gatedCtrl = holdSel ? heldCtrl : mCtrl;

	assign slot = gatedCtrl.haddr[30:28];
	assign slotDec = slotMask_t'(1) << slot;
	assign isTransfer = (gatedCtrl.htrans != IDLE);
	assign inReserved = gatedCtrl.haddr[31];

	assign saddrSel = (isTransfer && !inReserved) ? (slotDec & SlotEnable) : '0;

	// Disabled slots and the upper half go to the default slave
	assign reservedSel = isTransfer && (inReserved || !SlotEnable[slot]);

	always_comb
	begin
		for (int i = 0; i < NumSlots; i++)
			addrReadyVec[i] = sRsp[i].addrReady;
	end

	assign addrPending = |(saddrSel & ~addrReadyVec);	// Selected slot not ready

endmodule

// File: verilog/ahbPkg.sv
// AHB-Lite signal types for a 32-bit bus; HMASTLOCK and HPROT are not carried

package ahbPkg;

	typedef logic [31:0] addr_t;	// Byte address
	typedef logic [31:0] data_t;	// Read data word
	typedef logic [2:0] hsize_t;
	typedef logic [2:0] hburst_t;

	// Anything but IDLE is a transfer
	typedef enum logic [1:0]
	{
		IDLE = 2'b00,
		BUSY = 2'b01,
		NONSEQ = 2'b10,
		SEQ = 2'b11
	} htrans_e;

	typedef enum logic
	{
		OKAY = 1'b0,
		ERROR = 1'b1
	} hresp_e;

	// Address-phase bundle from master to stage and from stage to slaves
	typedef struct packed
	{
		addr_t haddr;
		htrans_e htrans;
		hsize_t hsize;
		hburst_t hburst;
		logic hwrite;
	} ahbCtrl_t;

endpackage

// File: verilog/dataPhaseSelect.sv
// Data-phase select and response mux; assumes saddrSel is one-hot or zero and never set with reservedSel
`timescale 1ns/1ns

module dataPhaseSelect
(
	input  logic HCLK,
	input  logic aresetn,
	input  matrixPkg::slotMask_t saddrSel,
	input  logic reservedSel,
	input  matrixPkg::slotRspArr_t sRsp,
	input  logic defReady,
	input  ahbPkg::hresp_e defResp,
	output matrixPkg::slotMask_t sdataSel,
	output logic defSel,
	output logic hreadyM,
	output ahbPkg::hresp_e hresp,
	output ahbPkg::data_t hrdata
);

	import ahbPkg::*;
	import matrixPkg::*;

	logic reservedData;
	logic slotReady;
	hresp_e slotResp;
	data_t slotData;

	// Advances only when the current data phase completes
	always_ff @(posedge HCLK or negedge aresetn)
	begin
		if (!aresetn)
		begin
			sdataSel <= '0;
			reservedData <= 1'b0;
		end
		else if (hreadyM)
		begin
			sdataSel <= saddrSel;
			reservedData <= reservedSel;
		end
	end

	always_comb
	begin
		// Idle data phase answers ready with OKAY
		slotReady = 1'b1;
		slotResp = OKAY;
		slotData = '0;
		for (int i = 0; i < NumSlots; i++)
		begin
			if (sdataSel[i])
			begin
				slotReady = sRsp[i].hreadyout;
				slotResp = sRsp[i].hresp;
				slotData = sRsp[i].hrdata;
			end
		end
	end

	assign defSel = reservedData;

	assign hreadyM = reservedData ? defReady : slotReady;
	assign hresp = reservedData ? defResp : slotResp;
	assign hrdata = reservedData ? '0 : slotData;	// Default slave returns zero

endmodule

// File: verilog/errorResponseTimer.sv
// Default slave with a two-phase ERROR; ErrWaitStates must be 1 to 7
`timescale 1ns/1ns

module errorResponseTimer
#(
	parameter int unsigned ErrWaitStates = 1
)
(
	input  logic HCLK,
	input  logic aresetn,
	input  logic defSel,
	output logic defReady,
	output ahbPkg::hresp_e defResp
);

	import ahbPkg::*;

	logic [2:0] waitCount;
	logic countDone;

	assign countDone = (waitCount == 3'(ErrWaitStates));

	always_ff @(posedge HCLK or negedge aresetn)
	begin
		if (!aresetn)
			waitCount <= '0;
		else if (defSel && !countDone)
			waitCount <= waitCount + 3'd1;
		else
			waitCount <= '0;	// Clears after the ready cycle
	end

	// Low for ErrWaitStates cycles, then one ready cycle
	assign defReady = !defSel || countDone;
	assign defResp = defSel ? ERROR : OKAY;

endmodule

// File: verilog/masterStage.sv
// Single-master stage of an 8-slot AHB-Lite matrix; no remap, no HMASTLOCK, async reset only
`timescale 1ns/1ns

module masterStage
#(
	parameter matrixPkg::slotMask_t SlotEnable = '1,
	parameter int unsigned ErrWaitStates = 1
)
(
	input  logic HCLK,
	input  logic aresetn,
	input  ahbPkg::ahbCtrl_t mCtrl,
	output logic hreadyM,
	output ahbPkg::hresp_e hresp,
	output ahbPkg::data_t hrdata,
	output ahbPkg::ahbCtrl_t gatedCtrl,
	output matrixPkg::slotMask_t saddrSel,
	output matrixPkg::slotMask_t sdataSel,
	input  matrixPkg::slotRspArr_t sRsp
);

	import ahbPkg::*;

	logic addrPending;
	logic capture;
	logic holdSel;
	logic reservedSel;
	logic defSel;
	logic defReady;
	hresp_e defResp;

	addrHoldFsm holdFsm_i
	(
		.HCLK(HCLK),
		.aresetn(aresetn),
		.addrPending(addrPending),
		.hreadyM(hreadyM),
		.capture(capture),
		.holdSel(holdSel)
	);

	addressStage #(
		.SlotEnable(SlotEnable)
	) addrStage_i (
		.HCLK(HCLK),
		.aresetn(aresetn),
		.mCtrl(mCtrl),
		.capture(capture),
		.holdSel(holdSel),
		.sRsp(sRsp),
		.gatedCtrl(gatedCtrl),
		.saddrSel(saddrSel),
		.reservedSel(reservedSel),
		.addrPending(addrPending)
	);

	// hreadyM doubles as the internal ready for the data select
	dataPhaseSelect dataSel_i
	(
		.HCLK(HCLK),
		.aresetn(aresetn),
		.saddrSel(saddrSel),
		.reservedSel(reservedSel),
		.sRsp(sRsp),
		.defReady(defReady),
		.defResp(defResp),
		.sdataSel(sdataSel),
		.defSel(defSel),
		.hreadyM(hreadyM),
		.hresp(hresp),
		.hrdata(hrdata)
	);

	errorResponseTimer #(
		.ErrWaitStates(ErrWaitStates)
	) defSlave_i (
		.HCLK(HCLK),
		.aresetn(aresetn),
		.defSel(defSel),
		.defReady(defReady),
		.defResp(defResp)
	);

endmodule

// File: verilog/matrixPkg.sv
// Slot-level types for one master and eight slots; slot count is fixed here, not per instance

package matrixPkg;

	localparam int NumSlots = 8;

	typedef logic [$clog2(NumSlots)-1:0] slotIdx_t;
	typedef logic [NumSlots-1:0] slotMask_t;	// One-hot select or enable mask

	// One slot's return path
	typedef struct packed
	{
		ahbPkg::data_t hrdata;
		logic hreadyout;	// Also serves as data-ready
		ahbPkg::hresp_e hresp;
		logic addrReady;	// Low refuses a live address
	} slotRsp_t;

	typedef slotRsp_t [NumSlots-1:0] slotRspArr_t;

endpackage
